// File: hw/rv_exe_consts.svh
`ifndef RV_EXE_CONSTS_SVH
`define RV_EXE_CONSTS_SVH

// widths
`define RV_XLEN       32    // data and address width
`define RV_REG_IDX_W  5     // x0..x31
`define RV_ALU_OP_W   4

// ================================================
// alu op codes, arithmetic and logic first
// ================================================
`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_SLL    4'd2
`define RV_ALU_SLT    4'd3
`define RV_ALU_SLTU   4'd4
`define RV_ALU_XOR    4'd5
`define RV_ALU_SRL    4'd6
`define RV_ALU_SRA    4'd7
`define RV_ALU_OR     4'd8
`define RV_ALU_AND    4'd9
// branch compares, only drive cmp
`define RV_ALU_BEQ    4'd10
`define RV_ALU_BNE    4'd11
`define RV_ALU_BLT    4'd12
`define RV_ALU_BGE    4'd13
`define RV_ALU_BLTU   4'd14
`define RV_ALU_BGEU   4'd15

// writeback result source
`define RV_RES_ALU    2'd0
`define RV_RES_IMM    2'd1  // lui style
`define RV_RES_PC4    2'd2  // jal / jalr link value

`endif

// File: hw/rv_types_pkg.sv
`default_nettype none

`include "rv_exe_consts.svh"

// scalar types shared by all stages
package rv_types_pkg;

    // ================================================
    // data path
    // ================================================
    typedef logic [`RV_XLEN-1:0] xlen_t;       // data word, also pc

    // ================================================
    // register file addressing
    // ================================================
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;  // rd / rs index

    // ================================================
    // control fields
    // ================================================
    typedef logic [`RV_ALU_OP_W-1:0] alu_op_t;    // one of RV_ALU_*
    typedef logic [1:0] res_src_t;                // one of RV_RES_*

endpackage

`default_nettype wire

// File: hw/rv_pipe_pkg.sv
`default_nettype none

// structs handed from stage to stage
package rv_pipe_pkg;

    import rv_types_pkg::*;

    // decoded micro-op, id -> exe
    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        xlen_t    rs1_val;      // operand a
        xlen_t    rs2_val;
        xlen_t    imm;          // sign extended already
        alu_op_t  alu_op;
        logic     use_imm;      // b = imm instead of rs2
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     pred_taken;   // static prediction from fetch
        reg_idx_t rd;
        logic     reg_write;
        res_src_t res_src;
    } id_exe_t;

    // registered exe result, exe -> wb
    typedef struct packed {
        logic     valid;
        xlen_t    alu_result;
        xlen_t    imm;
        xlen_t    pc_plus4;
        reg_idx_t rd;
        logic     reg_write;
        res_src_t res_src;
    } exe_wb_t;

    // regfile write port
    typedef struct packed {
        logic     valid;
        logic     we;           // never set for x0
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

    // fetch redirect
    typedef struct packed {
        logic  valid;
        xlen_t pc;
    } redirect_t;

endpackage

`default_nettype wire

// File: hw/id_exe_reg.sv
`default_nettype none

// id/exe pipeline register
// stall holds, flush and reset kill the entry
module id_exe_reg
    import rv_pipe_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire logic    stall_i,   // hold level
    input  wire logic    flush_i,   // kill level, wins over stall
    input  wire id_exe_t uop_i,
    output id_exe_t      uop_o
);

    // ================================================
    // state
    // ================================================
    logic    valid_q;       // control, reset
    id_exe_t payload_q;     // valid field here is ignored

    // ================================================
    // valid bit
    // ================================================
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;            // flush checked before stall
        end else if (!stall_i) begin
            valid_q <= uop_i.valid;
        end
        // stalled, keep
    end

    // ================================================
    // payload
    // ================================================
    // payload regs have no reset
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            payload_q <= uop_i;         // pc, operands, control fields
        end
    end

    // merge valid back into the struct
    always_comb begin
        uop_o       = payload_q;
        uop_o.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: hw/rv_alu.sv
`default_nettype none

`include "rv_exe_consts.svh"

// combinational alu
// arithmetic / logic ops drive result, branch compares drive cmp
module rv_alu
    import rv_types_pkg::*;
(
    input  wire xlen_t   a_i,
    input  wire xlen_t   b_i,
    input  wire alu_op_t op_i,
    output xlen_t        result_o,
    output logic         cmp_o      // branch condition true
);

    // ================================================
    // shared terms
    // ================================================
    logic [4:0] shamt;          // rv32, low five bits only
    logic       lt_s;           // signed a < b
    logic       lt_u;           // unsigned a < b
    logic       eq;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;
    assign eq    = a_i == b_i;

    // ================================================
    // result
    // ================================================
    always_comb begin
        result_o = '0;  // compares leave it zero
        case (op_i)
            `RV_ALU_ADD:  result_o = a_i + b_i;
            `RV_ALU_SUB:  result_o = a_i - b_i;
            `RV_ALU_SLL:  result_o = a_i << shamt;
            `RV_ALU_SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
            `RV_ALU_SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
            `RV_ALU_XOR:  result_o = a_i ^ b_i;
            `RV_ALU_SRL:  result_o = a_i >> shamt;
            `RV_ALU_SRA:  result_o = xlen_t'($signed(a_i) >>> shamt);  // sign fill
            `RV_ALU_OR:   result_o = a_i | b_i;
            `RV_ALU_AND:  result_o = a_i & b_i;
            default:      result_o = '0;
        endcase
    end

    // ================================================
    // branch compare
    // ================================================
    always_comb begin
        cmp_o = 1'b0;   // arithmetic ops never take a branch
        case (op_i)
            `RV_ALU_BEQ:  cmp_o = eq;
            `RV_ALU_BNE:  cmp_o = !eq;
            `RV_ALU_BLT:  cmp_o = lt_s;
            `RV_ALU_BGE:  cmp_o = !lt_s;     // ge is not lt
            `RV_ALU_BLTU: cmp_o = lt_u;
            `RV_ALU_BGEU: cmp_o = !lt_u;
            default:      cmp_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/exe_stage.sv
`default_nettype none

`include "rv_exe_consts.svh"

// execute stage
// alu, branch resolution against the static prediction, ex/wb register
module exe_stage
    import rv_types_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire logic    stall_i,
    input  wire id_exe_t uop_i,
    output exe_wb_t      exe_o,
    output redirect_t    redirect_o     // comb and gated by stall
);

    // ================================================
    // operand select
    // ================================================
    xlen_t   alu_a;
    xlen_t   alu_b;
    alu_op_t alu_op;
    xlen_t   alu_result;
    logic    alu_cmp;

    assign alu_a = uop_i.rs1_val;

    always_comb begin
        if (uop_i.is_branch) begin
            alu_b  = uop_i.rs2_val;     // compare rs1 against rs2
            alu_op = uop_i.alu_op;
        end else if (uop_i.is_jalr) begin
            alu_b  = uop_i.imm;         // jalr target sum rs1 + imm
            alu_op = `RV_ALU_ADD;
        end else begin
            alu_b  = uop_i.use_imm ? uop_i.imm : uop_i.rs2_val;
            alu_op = uop_i.alu_op;
        end
    end

    rv_alu i_alu (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .result_o (alu_result),
        .cmp_o    (alu_cmp)
    );

    // ================================================
    // branch resolution
    // ================================================
    xlen_t pc_plus4;
    xlen_t pc_plus_imm;
    xlen_t jalr_target;
    logic  actual_taken;
    logic  mispredict;

    assign pc_plus4    = uop_i.pc + xlen_t'(4);
    assign pc_plus_imm = uop_i.pc + uop_i.imm;                          // branch / jal
    assign jalr_target = {alu_result[`RV_XLEN-1:1], 1'b0};              // lsb cleared

    assign actual_taken = uop_i.is_jal || uop_i.is_jalr ||
                          (uop_i.is_branch && alu_cmp);
    assign mispredict   = actual_taken != uop_i.pred_taken;

    // jalr target is never known upstream so it always redirects
    assign redirect_o.valid = uop_i.valid && (mispredict || uop_i.is_jalr) && !stall_i;

    always_comb begin
        if (uop_i.is_jalr) begin
            redirect_o.pc = jalr_target;
        end else if (actual_taken) begin
            redirect_o.pc = pc_plus_imm;
        end else begin
            redirect_o.pc = pc_plus4;   // predicted taken but fell through
        end
    end

    // ================================================
    // ex/wb register
    // ================================================
    exe_wb_t exe_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exe_q.valid <= 1'b0;
        end else if (!stall_i) begin
            exe_q.valid <= uop_i.valid;
        end
        if (!stall_i) begin
            exe_q.alu_result <= alu_result;
            exe_q.imm        <= uop_i.imm;
            exe_q.pc_plus4   <= pc_plus4;       // link value for jal / jalr
            exe_q.rd         <= uop_i.rd;
            exe_q.reg_write  <= uop_i.reg_write;
            exe_q.res_src    <= uop_i.res_src;
        end
    end

    assign exe_o = exe_q;

endmodule

`default_nettype wire

// File: hw/wb_select_stage.sv
`default_nettype none

`include "rv_exe_consts.svh"

// writeback select, picks regfile data and masks x0 writes
module wb_select_stage
    import rv_types_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire logic    stall_i,
    input  wire exe_wb_t exe_i,
    output wb_t          wb_o
);

    // ================================================
    // data mux and write enable
    // ================================================
    xlen_t wb_data;
    logic  wb_we;

    always_comb begin
        case (exe_i.res_src)
            `RV_RES_IMM: wb_data = exe_i.imm;
            `RV_RES_PC4: wb_data = exe_i.pc_plus4;
            default:     wb_data = exe_i.alu_result;   // RV_RES_ALU
        endcase
    end

    assign wb_we = exe_i.valid && exe_i.reg_write && (exe_i.rd != '0);  // x0 stays zero

    // ================================================
    // output register
    // ================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o.valid <= 1'b0;
            wb_o.we    <= 1'b0;
        end else if (!stall_i) begin
            wb_o.valid <= exe_i.valid;
            wb_o.we    <= wb_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_o.rd   <= exe_i.rd;
            wb_o.data <= wb_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/exe_pipe_top.sv
`default_nettype none

// execute pipe top
// id/exe reg -> exe stage -> wb select
module exe_pipe_top
    import rv_pipe_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire logic    stall_i,    // global hold
    input  wire logic    flush_i,    // kills id/exe entry only
    input  wire id_exe_t uop_i,      // from decoder
    output wb_t          wb_o,       // to regfile
    output redirect_t    redirect_o  // to fetch
);

    // ================================================
    // stage links
    // ================================================
    id_exe_t exe_uop;       // id/exe reg -> exe
    exe_wb_t exe_wb;        // exe -> wb

    id_exe_reg i_id_exe_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .uop_i   (uop_i),
        .uop_o   (exe_uop)
    );

    exe_stage i_exe_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .uop_i      (exe_uop),
        .exe_o      (exe_wb),
        .redirect_o (redirect_o)
    );

    wb_select_stage i_wb_select_stage (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .exe_i   (exe_wb),
        .wb_o    (wb_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`default_nettype none

// free running testbench clock
module tb_clkgen #(
    parameter int HALF_PERIOD_NS = 4    // 8 ns period
) (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: tb/exe_pipe_assertions.sv
`default_nettype none

// port level properties of the execute pipe
module exe_pipe_assertions
    import rv_pipe_pkg::*;
(
    input wire logic      clk,
    input wire logic      reset_i,
    input wire logic      stall_i,
    input wire wb_t       wb_o,
    input wire redirect_t redirect_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // ================================================
    // reset, once the first edge has cleared the valids
    // ================================================
    reset_no_redirect: assert property (@(posedge clk)
        (reset_i && $past(reset_i)) |-> !redirect_o.valid)
        else $error("redirect_o.valid high during reset");

    reset_no_wb: assert property (@(posedge clk)
        (reset_i && $past(reset_i)) |-> (!wb_o.valid && !wb_o.we))
        else $error("wb_o valid or we high during reset");

    // ================================================
    // stall holds the wb register
    // ================================================
    stall_holds_wb: assert property (@(posedge clk)
        (stall_i && !reset_i) |=> $stable(wb_o))   // next sample equals this one
        else $error("wb_o changed while stalled");

endmodule

bind exe_pipe_top exe_pipe_assertions i_assertions (
    .clk        (clk),
    .reset_i    (reset_i),
    .stall_i    (stall_i),
    .wb_o       (wb_o),
    .redirect_o (redirect_o)
);

`default_nettype wire

// File: tb/exe_pipe_tb.sv
`default_nettype none

`include "rv_exe_consts.svh"

// random micro-ops through the execute pipe against a stage by stage model
module exe_pipe_tb
    import rv_types_pkg::*;
    import rv_pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SEED_VAL = 32'h1b3eb15b;
    localparam int NUM_CYCLES   = 3000;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_PERIOD   = 8;
    localparam int TIMEOUT_NS   = (NUM_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;  // loop + margin

    logic      clk;
    logic      reset;
    logic      stall;
    logic      flush;
    id_exe_t   uop;
    wb_t       wb;
    redirect_t redirect;

    // model copies of the three stage registers
    id_exe_t   m_ide;
    exe_wb_t   m_ew;
    wb_t       m_wb;
    int        errors;

    tb_clkgen #(.HALF_PERIOD_NS(CLK_PERIOD / 2)) i_clkgen (.clk_o(clk));

    exe_pipe_top i_dut (
        .clk        (clk),
        .reset_i    (reset),
        .stall_i    (stall),
        .flush_i    (flush),
        .uop_i      (uop),
        .wb_o       (wb),
        .redirect_o (redirect)
    );

    // ================================================
    // reference rules
    // ================================================
    function automatic logic signed_less(xlen_t a, xlen_t b);
        return (a[`RV_XLEN-1] != b[`RV_XLEN-1]) ? a[`RV_XLEN-1] : (a < b);  // sign bits decide first
    endfunction

    function automatic xlen_t alu_value(alu_op_t op, xlen_t a, xlen_t b);
        logic [2*`RV_XLEN-1:0] sext;
        sext = {{`RV_XLEN{a[`RV_XLEN-1]}}, a} >> b[4:0];   // arithmetic shift via sign extension
        case (op)
            `RV_ALU_ADD:  return a + b;
            `RV_ALU_SUB:  return a - b;
            `RV_ALU_SLL:  return a << b[4:0];
            `RV_ALU_SLT:  return xlen_t'(signed_less(a, b));
            `RV_ALU_SLTU: return xlen_t'(a < b);
            `RV_ALU_XOR:  return a ^ b;
            `RV_ALU_SRL:  return a >> b[4:0];
            `RV_ALU_SRA:  return sext[`RV_XLEN-1:0];
            `RV_ALU_OR:   return a | b;
            `RV_ALU_AND:  return a & b;
            default:      return '0;        // compares give zero
        endcase
    endfunction

    function automatic logic branch_taken(alu_op_t op, xlen_t a, xlen_t b);
        case (op)
            `RV_ALU_BEQ:  return a == b;
            `RV_ALU_BNE:  return a != b;
            `RV_ALU_BLT:  return signed_less(a, b);
            `RV_ALU_BGE:  return !signed_less(a, b);
            `RV_ALU_BLTU: return a < b;
            `RV_ALU_BGEU: return !(a < b);
            default:      return 1'b0;
        endcase
    endfunction

    function automatic exe_wb_t execute_uop(id_exe_t u);
        exe_wb_t r;
        xlen_t   b;
        b = (u.use_imm && !u.is_branch) ? u.imm : u.rs2_val;   // branches compare rs2
        r.valid      = u.valid;
        if (u.is_jalr) begin
            r.alu_result = u.rs1_val + u.imm;   // jalr sum whatever the op field says
        end else begin
            r.alu_result = alu_value(u.alu_op, u.rs1_val, b);
        end
        r.imm        = u.imm;
        r.pc_plus4   = u.pc + 32'd4;
        r.rd         = u.rd;
        r.reg_write  = u.reg_write;
        r.res_src    = u.res_src;
        return r;
    endfunction

    function automatic redirect_t resolve_redirect(id_exe_t u, logic stalled);
        redirect_t r;
        logic      taken;
        taken   = u.is_jal || u.is_jalr ||
                  (u.is_branch && branch_taken(u.alu_op, u.rs1_val, u.rs2_val));
        r.valid = u.valid && !stalled && ((taken != u.pred_taken) || u.is_jalr);
        if (u.is_jalr) begin
            r.pc = (u.rs1_val + u.imm) & ~xlen_t'(1);
        end else if (taken) begin
            r.pc = u.pc + u.imm;
        end else begin
            r.pc = u.pc + 32'd4;        // wrong taken guess
        end
        return r;
    endfunction

    function automatic wb_t select_writeback(exe_wb_t e);
        wb_t w;
        w.valid = e.valid;
        w.we    = e.valid && e.reg_write && (e.rd != '0);
        w.rd    = e.rd;
        case (e.res_src)
            `RV_RES_IMM: w.data = e.imm;
            `RV_RES_PC4: w.data = e.pc_plus4;
            default:     w.data = e.alu_result;
        endcase
        return w;
    endfunction

    // one rising edge of the model with the oldest stage first
    task automatic model_edge();
        if (!stall) begin
            m_wb  = select_writeback(m_ew);
            m_ew  = execute_uop(m_ide);
            m_ide = uop;
        end
        if (flush) begin
            m_ide.valid = 1'b0;         // payload may still hold
        end
        if (reset) begin
            m_ide.valid = 1'b0;
            m_ew.valid  = 1'b0;
            m_wb.valid  = 1'b0;
            m_wb.we     = 1'b0;
        end
    endtask

    // ================================================
    // stimulus
    // ================================================
    function automatic id_exe_t random_uop();
        id_exe_t u;
        int      kind;
        u           = '0;
        kind        = int'($urandom_range(7, 0));
        u.valid     = ($urandom_range(7, 0) != 0);
        u.pc        = $urandom() & ~32'h3;
        u.rs1_val   = $urandom();
        u.rs2_val   = ($urandom_range(3, 0) == 0) ? u.rs1_val : $urandom();  // equal operands
        u.imm       = $urandom();
        u.rd        = ($urandom_range(5, 0) == 0) ? '0 : reg_idx_t'($urandom());
        u.reg_write = ($urandom_range(7, 0) != 0);
        u.use_imm   = ($urandom_range(1, 0) == 1);
        u.alu_op    = alu_op_t'($urandom_range(9, 0));
        u.res_src   = `RV_RES_ALU;
        case (kind)
            4: u.res_src = `RV_RES_IMM;             // lui style
            5: begin
                u.is_branch  = 1'b1;
                u.alu_op     = alu_op_t'($urandom_range(15, 10));
                u.pred_taken = ($urandom_range(1, 0) == 1);
                u.reg_write  = 1'b0;
            end
            6: begin
                u.is_jal     = 1'b1;
                u.res_src    = `RV_RES_PC4;
                u.pred_taken = ($urandom_range(1, 0) == 1);
            end
            7: begin
                u.is_jalr    = 1'b1;                 // op and use_imm stay random
                u.res_src    = `RV_RES_PC4;
                u.pred_taken = ($urandom_range(1, 0) == 1);
            end
            default: ;
        endcase
        return u;
    endfunction

    // ================================================
    // checks
    // ================================================
    task automatic fail_and_stop();
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wb(wb_t act, wb_t exp);
        logic bad;
        bad = (act.valid !== exp.valid) || (act.we !== exp.we);
        if (exp.valid) begin
            bad = bad || (act.rd !== exp.rd) || (act.data !== exp.data);
        end
        if (bad) begin
            errors++;
            $display("[FAIL] wb_o: got %h expected %h", act, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_redirect(redirect_t act, redirect_t exp);
        logic bad;
        bad = (act.valid !== exp.valid);
        if (exp.valid) begin
            bad = bad || (act.pc !== exp.pc);   // pc only matters when valid
        end
        if (bad) begin
            errors++;
            $display("[FAIL] redirect_o: got %h expected %h", act, exp);
            fail_and_stop();
        end
    endtask

    // ================================================
    // main sequence and watchdog
    // ================================================
    initial begin
        void'($urandom(SEED_VAL));
        errors = 0;
        reset  = 1'b1;
        stall  = 1'b0;
        flush  = 1'b0;
        uop    = '0;
        m_ide  = '0;
        m_ew   = '0;
        m_wb   = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            model_edge();
        end
        #1;
        reset = 1'b0;
        #2;
        check_wb(wb, m_wb);                         // idle right after reset
        check_redirect(redirect, resolve_redirect(m_ide, stall));
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            model_edge();
            #1;                                     // drive after the edge
            stall = ($urandom_range(9, 0) == 0);
            flush = ($urandom_range(11, 0) == 0);
            uop   = random_uop();
            #2;
            check_wb(wb, m_wb);
            check_redirect(redirect, resolve_redirect(m_ide, stall));
        end
        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_and_stop();
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the stimulus loop finished");
        fail_and_stop();
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/rv_types_pkg.sv
hw/rv_pipe_pkg.sv
hw/id_exe_reg.sv
hw/rv_alu.sv
hw/exe_stage.sv
hw/wb_select_stage.sv
hw/exe_pipe_top.sv
tb/tb_clkgen.sv
tb/exe_pipe_assertions.sv
tb/exe_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module exe_pipe_tb -Mdir obj_dir \
    && ./obj_dir/Vexe_pipe_tb \
    || { echo "simulation build or run failed"; exit 1; }
